// ==== hdl/cpu_pkg.sv ====
package cpu_pkg;

  localparam int xlen      = 32;
  localparam int reg_count = 32;

  typedef logic [xlen-1:0] word_t;
  typedef logic [4:0]      reg_addr_t;

  localparam word_t reset_pc  = 32'h0000_0000;
  localparam word_t nop_instr = 32'h0000_0013; // addi x0, x0, 0

  typedef enum logic [6:0] {
    op_reg   = 7'b0110011,
    op_imm   = 7'b0010011,
    op_lui   = 7'b0110111,
    op_load  = 7'b0000011,
    op_store = 7'b0100011
  } opcode_e;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_and, alu_or, alu_xor,
    alu_sll, alu_srl, alu_sra, alu_slt, alu_sltu
  } alu_op_e;

  typedef struct packed {
    logic    reg_write;
    logic    mem_read;
    logic    mem_write;
    logic    mem_to_reg;
    logic    alu_src;   // operand b from immediate
    alu_op_e alu_op;
  } ctrl_t;

  typedef struct packed {
    word_t instr;
  } if_id_t;

  typedef struct packed {
    ctrl_t     ctrl;
    word_t     rs1_data;
    word_t     rs2_data;
    word_t     imm;
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
  } id_ex_t;

  typedef struct packed {
    ctrl_t     ctrl;
    word_t     alu_result;
    word_t     store_data;
    reg_addr_t rd;
  } ex_mem_t;

  typedef struct packed {
    logic      reg_write;
    reg_addr_t rd;
    word_t     wb_data;
  } mem_wb_t;

endpackage

// ==== hdl/fetch_stage.sv ====
module fetch_stage import cpu_pkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  input  logic   mem_wait,
  input  logic   load_stall,
  input  word_t  instr,
  output word_t  instr_addr,
  output if_id_t if_id
);

  word_t pc;
  logic  advance;

  assign advance    = !mem_wait && !load_stall;
  assign instr_addr = pc;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= reset_pc;
    end else if (advance) begin
      pc <= pc + 32'd4;
    end
  end

  // if/id keeps the instruction under either stall
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      if_id.instr <= nop_instr;
    end else if (advance) begin
      if_id.instr <= instr;
    end
  end

endmodule

// ==== hdl/register_file.sv ====
module register_file import cpu_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      mem_wait,
  input  mem_wb_t   wb,
  input  reg_addr_t rs1,
  input  reg_addr_t rs2,
  output word_t     rs1_data,
  output word_t     rs2_data
);

  word_t regs [1:reg_count-1]; // x0 not stored

  function automatic word_t read_port(input reg_addr_t idx);
    if (idx == '0) return '0;
    if (wb.reg_write && wb.rd == idx) return wb.wb_data; // write-through
    return regs[idx];
  endfunction

  assign rs1_data = read_port(rs1);
  assign rs2_data = read_port(rs2);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 1; i < reg_count; i++) regs[i] <= '0;
    end else if (wb.reg_write && !mem_wait && wb.rd != '0) begin
      regs[wb.rd] <= wb.wb_data;
    end
  end

  // a written register reads back unless a newer write targets it
  write_read_back: assert property (@(posedge clk) disable iff (!rst_n)
    wb.reg_write && !mem_wait && wb.rd != '0 |=>
      rs1 != $past(wb.rd) || (wb.reg_write && wb.rd == rs1) ||
      rs1_data == $past(wb.wb_data));

endmodule

// ==== hdl/decode_stage.sv ====
module decode_stage import cpu_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      mem_wait,
  input  if_id_t    if_id,
  input  word_t     rs1_data,
  input  word_t     rs2_data,
  output reg_addr_t rs1,
  output reg_addr_t rs2,
  output logic      load_stall,
  output id_ex_t    id_ex
);

  word_t   instr;
  opcode_e opcode;
  logic    [2:0] funct3;
  logic    alt;      // instr bit 30
  ctrl_t   ctrl;
  word_t   imm;
  id_ex_t  id_ex_next;

  function automatic alu_op_e funct_op(input logic [2:0] f3, input logic sel);
    case (f3)
      3'b000:  return sel ? alu_sub : alu_add;
      3'b001:  return alu_sll;
      3'b010:  return alu_slt;
      3'b011:  return alu_sltu;
      3'b100:  return alu_xor;
      3'b101:  return sel ? alu_sra : alu_srl;
      3'b110:  return alu_or;
      default: return alu_and;
    endcase
  endfunction

  assign instr  = if_id.instr;
  assign opcode = opcode_e'(instr[6:0]);
  assign funct3 = instr[14:12];
  assign alt    = instr[30];

  // unused source fields forced to x0 so they never stall or forward
  assign rs1 = (opcode == op_lui) ? '0 : instr[19:15];
  assign rs2 = (opcode == op_reg || opcode == op_store) ? instr[24:20] : '0;

  always_comb begin
    ctrl = '0;
    ctrl.alu_op = alu_add;
    case (opcode)
      op_reg: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_op    = funct_op(funct3, alt);
      end
      op_imm: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_src   = 1'b1;
        ctrl.alu_op    = funct_op(funct3, alt && funct3 == 3'b101); // no subi
      end
      op_lui: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_src   = 1'b1;  // x0 + upper immediate
      end
      op_load: begin
        ctrl.reg_write  = 1'b1;
        ctrl.mem_read   = 1'b1;
        ctrl.mem_to_reg = 1'b1;
        ctrl.alu_src    = 1'b1;
      end
      op_store: begin
        ctrl.mem_write = 1'b1;
        ctrl.alu_src   = 1'b1;
      end
      default: ;
    endcase
  end

  always_comb begin
    case (opcode)
      op_store: imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      op_lui:   imm = {instr[31:12], 12'b0};
      default:  imm = {{20{instr[31]}}, instr[31:20]};
    endcase
  end

  assign load_stall = id_ex.ctrl.mem_read && id_ex.rd != '0 &&
                      (id_ex.rd == rs1 || id_ex.rd == rs2);

  assign id_ex_next = '{ctrl: ctrl, rs1_data: rs1_data, rs2_data: rs2_data,
                        imm: imm, rs1: rs1, rs2: rs2, rd: instr[11:7]};

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      id_ex <= '0;
    end else if (!mem_wait) begin
      id_ex <= load_stall ? '0 : id_ex_next; // bubble on load-use
    end
  end

  // the stalled instruction waits in if/id for its replay
  stalled_instr_held: assert property (@(posedge clk) disable iff (!rst_n)
    load_stall |=> $stable(if_id));

endmodule

// ==== hdl/execute_stage.sv ====
module execute_stage import cpu_pkg::*; (
  input  logic    clk,
  input  logic    rst_n,
  input  logic    mem_wait,
  input  id_ex_t  id_ex,
  input  mem_wb_t wb,
  output ex_mem_t ex_mem
);

  word_t   op_a;
  word_t   rs2_fwd;
  word_t   op_b;
  word_t   result;
  logic    [4:0] shamt;
  ex_mem_t ex_mem_next;

  // ex/mem wins over mem/wb, loads in ex/mem are covered by the stall
  function automatic word_t forward(input reg_addr_t rs, input word_t rf_data);
    if (ex_mem.ctrl.reg_write && !ex_mem.ctrl.mem_read &&
        ex_mem.rd != '0 && ex_mem.rd == rs) begin
      return ex_mem.alu_result;
    end
    if (wb.reg_write && wb.rd != '0 && wb.rd == rs) begin
      return wb.wb_data;
    end
    return rf_data;
  endfunction

  assign op_a    = forward(id_ex.rs1, id_ex.rs1_data);
  assign rs2_fwd = forward(id_ex.rs2, id_ex.rs2_data);
  assign op_b    = id_ex.ctrl.alu_src ? id_ex.imm : rs2_fwd;
  assign shamt   = op_b[4:0];

  always_comb begin
    case (id_ex.ctrl.alu_op)
      alu_add:  result = op_a + op_b;
      alu_sub:  result = op_a - op_b;
      alu_and:  result = op_a & op_b;
      alu_or:   result = op_a | op_b;
      alu_xor:  result = op_a ^ op_b;
      alu_sll:  result = op_a << shamt;
      alu_srl:  result = op_a >> shamt;
      alu_sra:  result = $signed(op_a) >>> shamt;
      alu_slt:  result = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      alu_sltu: result = {{(xlen-1){1'b0}}, op_a < op_b};
      default:  result = '0;
    endcase
  end

  assign ex_mem_next = '{ctrl: id_ex.ctrl, alu_result: result,
                         store_data: rs2_fwd, rd: id_ex.rd};

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ex_mem <= '0;
    end else if (!mem_wait) begin
      ex_mem <= ex_mem_next;
    end
  end

  // only whole words reach the data port
  store_aligned: assert property (@(posedge clk) disable iff (!rst_n)
    ex_mem.ctrl.mem_write |-> ex_mem.alu_result[1:0] == 2'b00);

endmodule

// ==== hdl/memory_writeback.sv ====
module memory_writeback import cpu_pkg::*; (
  input  logic    clk,
  input  logic    rst_n,
  input  logic    mem_wait,
  input  ex_mem_t ex_mem,
  input  word_t   data_rdata,
  output mem_wb_t wb
);

  word_t wb_sel;

  assign wb_sel = ex_mem.ctrl.mem_to_reg ? data_rdata : ex_mem.alu_result;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wb <= '0;
    end else if (!mem_wait) begin
      wb <= '{reg_write: ex_mem.ctrl.reg_write, rd: ex_mem.rd, wb_data: wb_sel};
    end
  end

endmodule

// ==== hdl/cpu.sv ====
module cpu import cpu_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  output word_t instr_addr,
  input  word_t instr,
  output word_t data_addr,
  output word_t data_wdata,
  output logic  data_we,
  output logic  data_re,
  input  word_t data_rdata,
  input  logic  mem_wait
);

  if_id_t    if_id;
  id_ex_t    id_ex;
  ex_mem_t   ex_mem;
  mem_wb_t   wb;
  logic      load_stall;
  reg_addr_t rs1;
  reg_addr_t rs2;
  word_t     rs1_data;
  word_t     rs2_data;

  fetch_stage fetch_i (
    .clk, .rst_n, .mem_wait, .load_stall,
    .instr, .instr_addr, .if_id
  );

  register_file regfile_i (
    .clk, .rst_n, .mem_wait, .wb,
    .rs1, .rs2, .rs1_data, .rs2_data
  );

  decode_stage decode_i (
    .clk, .rst_n, .mem_wait, .if_id,
    .rs1_data, .rs2_data, .rs1, .rs2,
    .load_stall, .id_ex
  );

  execute_stage execute_i (
    .clk, .rst_n, .mem_wait, .id_ex, .wb, .ex_mem
  );

  memory_writeback mem_wb_i (
    .clk, .rst_n, .mem_wait, .ex_mem, .data_rdata, .wb
  );

  // data port straight from ex/mem
  assign data_addr  = ex_mem.alu_result;
  assign data_wdata = ex_mem.store_data;
  assign data_we    = ex_mem.ctrl.mem_write;
  assign data_re    = ex_mem.ctrl.mem_read;

endmodule

// ==== verification/iss_model.svh ====
reg_addr_t last_rd = 5'd1;

function automatic word_t model_alu(input logic [2:0] f3, input logic alt,
                                    input word_t a, input word_t b);
  case (f3)
    3'b000:  return alt ? a - b : a + b;
    3'b001:  return a << b[4:0];
    3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    3'b011:  return (a < b) ? 32'd1 : 32'd0;
    3'b100:  return a ^ b;
    3'b101:  return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
    3'b110:  return a | b;
    default: return a & b;
  endcase
endfunction

// destinations stay in x1..x15
// about half the sources reuse the last rd
function automatic word_t random_instr();
  word_t       r;
  word_t       s;
  reg_addr_t   rd;
  reg_addr_t   rs1;
  reg_addr_t   rs2;
  logic [11:0] off;
  logic        alt;
  r   = next_rand();
  s   = next_rand();
  rd  = 5'd1 + {1'b0, r[31:28] % 4'd15};
  rs1 = r[27] ? last_rd : {1'b0, r[26:23]};
  rs2 = r[22] ? last_rd : {1'b0, r[21:18]};
  off = {4'b0, r[14:9], 2'b00}; // word aligned offset below 256
  alt = s[27] && (r[17:15] == 3'b000 || r[17:15] == 3'b101);
  if (s[31:28] < 4'd13) last_rd = rd;
  case (s[31:28])
    4'd0, 4'd1, 4'd2, 4'd3, 4'd4:
      return {1'b0, alt, 5'b0, rs2, rs1, r[17:15], rd, op_reg};
    4'd5, 4'd6, 4'd7, 4'd8: begin
      if (r[16:15] == 2'b01) begin
        return {1'b0, alt, 5'b0, s[26:22], rs1, r[17:15], rd, op_imm}; // shifts
      end
      return {s[26:15], rs1, r[17:15], rd, op_imm};
    end
    4'd9:                return {s[27:8], rd, op_lui};
    4'd10, 4'd11, 4'd12: return {off, 5'd0, 3'b010, rd, op_load};
    default:             return {off[11:5], rs2, 5'd0, 3'b010, off[4:0], op_store};
  endcase
endfunction

function automatic void build_program();
  logic [11:0] off;
  for (int i = 0; i < imem_words; i++) imem[i] = nop_instr;
  for (int i = 0; i < prog_len; i++) imem[i] = random_instr();
  // one dump store per register
  for (int i = 1; i < reg_count; i++) begin
    off = 12'(dump_base + 4 * i);
    imem[prog_len + i - 1] = {off[11:5], 5'(i), 5'd0, 3'b010, off[4:0], op_store};
  end
  for (int i = 0; i < dmem_words; i++) preload[i] = next_rand();
endfunction

// expected stores in program order
function automatic void run_model();
  word_t regs [reg_count];
  word_t mem [dmem_words];
  word_t ins;
  word_t a;
  word_t b;
  word_t imm_i;
  word_t addr;
  word_t res;
  regs = '{default: '0};
  mem  = preload;
  for (int pc = 0; pc < prog_len + reg_count - 1; pc++) begin
    ins   = imem[pc];
    a     = regs[ins[19:15]];
    b     = regs[ins[24:20]];
    imm_i = {{20{ins[31]}}, ins[31:20]};
    addr  = a + imm_i;
    res   = '0;
    case (ins[6:0])
      op_reg:  res = model_alu(ins[14:12], ins[30], a, b);
      op_imm:  res = model_alu(ins[14:12], ins[30] && ins[14:12] == 3'b101, a, imm_i);
      op_lui:  res = {ins[31:12], 12'b0};
      op_load: begin
        res = mem[addr[9:2]];
        exp_loads++;
      end
      default: begin
        addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
        mem[addr[9:2]] = b;
        exp_addr.push_back(addr);
        exp_data.push_back(b);
        if (pc < prog_len) exp_name.push_back($sformatf("store %0d", pc));
        else exp_name.push_back($sformatf("dump x%0d", ins[24:20]));
      end
    endcase
    if (ins[6:0] != op_store && ins[11:7] != '0) regs[ins[11:7]] = res;
  end
endfunction

// ==== verification/cpu_tb.sv ====
module cpu_tb import cpu_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int    prog_len       = 60;
  localparam int    imem_words     = 128;
  localparam int    dmem_words     = 256;
  localparam int    dump_base      = 512;
  localparam int    timeout_cycles = 5000;
  localparam int    drain_cycles   = 30;
  localparam word_t seed           = 32'h1325_7c7f;

  logic  clk = 1'b0;
  logic  rst_n;
  logic  mem_wait;
  word_t instr_addr;
  word_t instr;
  word_t data_addr;
  word_t data_wdata;
  logic  data_we;
  logic  data_re;
  word_t data_rdata;

  word_t imem [imem_words];
  word_t dmem [dmem_words];
  word_t preload [dmem_words];
  word_t lcg_state = seed;
  word_t exp_addr [$];
  word_t exp_data [$];
  string exp_name [$];
  int    exp_loads;
  int    stores_seen;
  int    loads_seen;
  int    value_errors;
  int    store_errors;

  function automatic word_t next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  `include "iss_model.svh"

  cpu cpu_i (
    .clk, .rst_n, .instr_addr, .instr, .data_addr, .data_wdata,
    .data_we, .data_re, .data_rdata, .mem_wait
  );

  always #10 clk = ~clk; // 20 ns period

  assign instr      = (instr_addr[31:9] == '0) ? imem[instr_addr[8:2]] : nop_instr;
  assign data_rdata = dmem[data_addr[9:2]];

  always @(posedge clk) begin
    if (!rst_n) begin // preload while in reset
      for (int i = 0; i < dmem_words; i++) dmem[i] <= preload[i];
    end else if (data_we && !mem_wait) begin // committed store
      dmem[data_addr[9:2]] <= data_wdata;
    end
  end

  task automatic check_word(input string name, input word_t expected, input word_t actual);
    if (actual !== expected) begin
      $display("error %s: expected %h, actual %h", name, expected, actual);
      value_errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("error %s: expected %b, actual %b", name, expected, actual);
      value_errors++;
    end
  endtask

  task automatic observe_data_port();
    if (data_re && !mem_wait) begin
      loads_seen++;
    end
    if (data_we && !mem_wait) begin
      if (stores_seen < exp_addr.size()) begin
        check_word({exp_name[stores_seen], " address"}, exp_addr[stores_seen], data_addr);
        check_word({exp_name[stores_seen], " data"}, exp_data[stores_seen], data_wdata);
      end else begin
        $display("unexpected store to %h after all %0d expected stores", data_addr,
                 exp_addr.size());
        store_errors++;
      end
      stores_seen++;
    end
  endtask

  // drive after the edge and sample at the falling edge
  task automatic run_cycle(input logic random_wait);
    @(posedge clk);
    #2;
    mem_wait = random_wait && (next_rand() < 32'h4000_0000); // about one in four
    @(negedge clk);
    observe_data_port();
  endtask

  initial begin
    int cycles;
    rst_n        = 1'b0;
    mem_wait     = 1'b0;
    exp_loads    = 0;
    stores_seen  = 0;
    loads_seen   = 0;
    value_errors = 0;
    store_errors = 0;
    build_program();
    run_model();
    repeat (3) @(posedge clk);
    #2;
    rst_n = 1'b1;
    check_word("reset instr_addr", reset_pc, instr_addr);
    check_flag("reset data_we", 1'b0, data_we);
    check_flag("reset data_re", 1'b0, data_re);
    repeat (2) begin
      run_cycle(1'b0);
      check_flag("early data_we", 1'b0, data_we); // first instr not in mem yet
      check_flag("early data_re", 1'b0, data_re);
    end
    cycles = 0;
    while (stores_seen < exp_addr.size() && cycles < timeout_cycles) begin
      run_cycle(1'b1);
      cycles++;
    end
    if (stores_seen < exp_addr.size()) begin
      $display("timeout after %0d cycles, only %0d of %0d stores seen", cycles,
               stores_seen, exp_addr.size());
      store_errors++;
    end
    repeat (drain_cycles) run_cycle(1'b1); // nop tail must not store
    check_word("load count", word_t'(exp_loads), word_t'(loads_seen));
    $display("errors: %0d value, %0d store count", value_errors, store_errors);
    if (value_errors == 0 && store_errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
+incdir+verification
hdl/cpu_pkg.sv
hdl/fetch_stage.sv
hdl/register_file.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/memory_writeback.sv
hdl/cpu.sv
verification/cpu_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module cpu_tb -f sim.f -o cpu_sim
./obj_dir/cpu_sim | tee sim.log
if ! grep -qx "STATUS: PASS" sim.log; then
  echo "simulation did not pass, see sim.log"
  exit 1
fi
echo "simulation passed"
